// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = uart_tb
FILELIST = filelist.f
BUILD    = obj_dir
PASS_MSG = Everything OK

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator, run it and check the result"
	@echo "  clean  remove the build directory"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	@out="$$(./$(BUILD)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD)

// File: filelist.f
src/uart_pkg.sv
src/uart_fifo.sv
src/uart_regs.sv
src/uart_tx.sv
src/uart_rx.sv
src/uart_top.sv
tb/uart_properties.sv
tb/uart_tb.sv

// File: src/uart_fifo.sv
// Synchronous circular-buffer FIFO with a type-parameter payload
module uart_fifo #(
    parameter type payload_t  = logic [7:0],
    parameter int  FIFO_DEPTH = 4
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     push_i,
    input  payload_t data_i,
    input  logic     pop_i,
    output payload_t data_o,
    output logic     full_o,
    output logic     empty_o
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);

    payload_t         mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             do_push;
    logic             do_pop;

    // Push when full and pop when empty are dropped
    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && !empty_o;

    assign full_o  = (count == (PTR_W + 1)'(FIFO_DEPTH));
    assign empty_o = (count == '0);

    // Head of queue is visible without a pop
    assign data_o = mem[rd_ptr];

    // Storage
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= data_i;
        end
    end

    // Pointers wrap on their own since depth is a power of two
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: src/uart_pkg.sv
// Shared UART definitions: bus structs, register map, status bit indices, receive entry type
package uart_pkg;

    // Widths
    localparam int XLEN        = 32;
    localparam int UART_DATA_W = 8;

    // Divider value out of reset
    localparam logic [7:0] BAUD_RESET = 8'd8;

    // --------------------------------------------------
    // Data bus
    // --------------------------------------------------
    typedef struct packed {
        logic            req;
        logic            w_en;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] w_data;
    } dbus_req_t;

    typedef struct packed {
        logic            ack;
        logic [XLEN-1:0] r_data;
    } dbus_rsp_t;

    // Register index from addr[5:2]
    typedef enum logic [3:0] {
        TXRX    = 4'd0,
        STATUS  = 4'd1,
        IE      = 4'd2,
        BAUD    = 4'd3,
        LCTRL   = 4'd4,
        SCRATCH = 4'd5
    } uart_reg_e;

    // Status register bits, 7 to 5 read as zero
    localparam int ST_RX_AVAIL   = 0;
    localparam int ST_TX_FULL    = 1;
    localparam int ST_TX_IDLE    = 2;
    localparam int ST_FRAME_ERR  = 3;
    localparam int ST_RX_OVERRUN = 4;

    // Received character with its framing flag
    typedef struct packed {
        logic [UART_DATA_W-1:0] data;
        logic                   frame_err;
    } rx_entry_t;

endpackage

// File: src/uart_regs.sv
// UART register block: bus decode, configuration and status registers, FIFO strobes, interrupt
module uart_regs (
    input  logic                              clk,
    input  logic                              rst_n,
    input  uart_pkg::dbus_req_t               dbus_req_i,
    output uart_pkg::dbus_rsp_t               dbus_rsp_o,
    input  logic                              sel_i,
    output logic                              irq_o,
    // Transmit FIFO side
    output logic                              tx_push_o,
    output logic [uart_pkg::UART_DATA_W-1:0]  tx_data_o,
    input  logic                              tx_full_i,
    input  logic                              tx_empty_i,
    // Receive FIFO side
    output logic                              rx_pop_o,
    input  uart_pkg::rx_entry_t               rx_entry_i,
    input  logic                              rx_empty_i,
    input  logic                              rx_overrun_i,
    // Line side
    input  logic                              tx_busy_i,
    output logic [7:0]                        baud_div_o,
    output logic                              two_stop_o
);

    import uart_pkg::*;

    uart_reg_e              reg_idx;
    logic                   access;
    logic                   rd_access;
    logic                   wr_access;
    logic                   ack_q;
    logic [XLEN-1:0]        r_data_q;
    logic [UART_DATA_W-1:0] ie_q;
    logic [7:0]             baud_q;
    logic [UART_DATA_W-1:0] lctrl_q;
    logic [UART_DATA_W-1:0] scratch_q;
    logic                   frame_err_q;
    logic                   overrun_q;
    logic                   irq_q;
    logic [UART_DATA_W-1:0] status;
    logic [UART_DATA_W-1:0] rd_byte;

    // --------------------------------------------------
    // Bus decode
    // --------------------------------------------------
    // A request during the ack cycle is not a new access
    assign reg_idx   = uart_reg_e'(dbus_req_i.addr[5:2]);
    assign access    = dbus_req_i.req && sel_i && !ack_q;
    assign rd_access = access && !dbus_req_i.w_en;
    assign wr_access = access && dbus_req_i.w_en;

    // FIFO strobes, full FIFO drops the write
    assign tx_push_o = wr_access && (reg_idx == TXRX) && !tx_full_i;
    assign tx_data_o = dbus_req_i.w_data[UART_DATA_W-1:0];
    assign rx_pop_o  = rd_access && (reg_idx == TXRX) && !rx_empty_i;

    always_comb begin
        status                = '0;
        status[ST_RX_AVAIL]   = !rx_empty_i;
        status[ST_TX_FULL]    = tx_full_i;
        status[ST_TX_IDLE]    = tx_empty_i && !tx_busy_i;
        status[ST_FRAME_ERR]  = frame_err_q;
        status[ST_RX_OVERRUN] = overrun_q;
    end

    // Read mux
    always_comb begin
        rd_byte = '0;
        case (reg_idx)
            TXRX: begin
                if (!rx_empty_i) begin
                    rd_byte = rx_entry_i.data;
                end
            end
            STATUS:  rd_byte = status;
            IE:      rd_byte = ie_q;
            BAUD:    rd_byte = baud_q;
            LCTRL:   rd_byte = lctrl_q;
            SCRATCH: rd_byte = scratch_q;
            default: rd_byte = '0;
        endcase
    end

    // --------------------------------------------------
    // Configuration registers
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ie_q      <= '0;
            baud_q    <= BAUD_RESET;
            lctrl_q   <= '0;
            scratch_q <= '0;
        end else if (wr_access) begin
            case (reg_idx)
                IE:      ie_q      <= dbus_req_i.w_data[UART_DATA_W-1:0];
                BAUD:    baud_q    <= dbus_req_i.w_data[7:0];
                LCTRL:   lctrl_q   <= dbus_req_i.w_data[UART_DATA_W-1:0];
                SCRATCH: scratch_q <= dbus_req_i.w_data[UART_DATA_W-1:0];
                default: ;
            endcase
        end
    end

    // Sticky bits, a new event wins over the clearing read
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            frame_err_q <= 1'b0;
            overrun_q   <= 1'b0;
        end else begin
            if (rd_access && (reg_idx == STATUS)) begin
                frame_err_q <= 1'b0;
                overrun_q   <= 1'b0;
            end
            if (rx_pop_o && rx_entry_i.frame_err) begin
                frame_err_q <= 1'b1;
            end
            if (rx_overrun_i) begin
                overrun_q <= 1'b1;
            end
        end
    end

    // --------------------------------------------------
    // Response and interrupt
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ack_q <= 1'b0;
            irq_q <= 1'b0;
        end else begin
            ack_q <= access;
            irq_q <= |(status & ie_q);
        end
    end

    always_ff @(posedge clk) begin
        if (rd_access) begin
            r_data_q <= {{(XLEN - UART_DATA_W){1'b0}}, rd_byte};
        end
    end

    assign dbus_rsp_o = '{ack: ack_q, r_data: r_data_q};
    assign irq_o      = irq_q;
    assign baud_div_o = baud_q;
    assign two_stop_o = lctrl_q[0];

endmodule

// File: src/uart_rx.sv
// UART receiver FSM: synchronizer, mid-bit sampling, framing check and FIFO push
module uart_rx (
    input  logic                clk,
    input  logic                rst_n,
    input  logic [7:0]          baud_div_i,
    input  logic                rxd_i,
    input  logic                full_i,
    output logic                push_o,
    output uart_pkg::rx_entry_t entry_o,
    output logic                overrun_o
);

    import uart_pkg::*;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_e;

    rx_state_e              state;
    logic                   rxd_meta;
    logic                   rxd_sync;
    logic                   rxd_prev;
    logic [7:0]             baud_cnt;
    logic [2:0]             bit_cnt;
    logic [UART_DATA_W-1:0] shreg;
    logic                   half_end;
    logic                   bit_end;
    logic                   stop_done;

    assign half_end  = (baud_cnt == (baud_div_i >> 1));
    assign bit_end   = (baud_cnt == baud_div_i);
    assign stop_done = (state == RX_STOP) && bit_end;

    // Entry leaves at the stop-bit sample, low stop bit flags the frame
    assign entry_o   = '{data: shreg, frame_err: !rxd_sync};
    assign push_o    = stop_done && !full_i;
    assign overrun_o = stop_done && full_i;

    // Two-flop synchronizer plus edge history, idle line is high
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
            rxd_prev <= 1'b1;
        end else begin
            rxd_meta <= rxd_i;
            rxd_sync <= rxd_meta;
            rxd_prev <= rxd_sync;
        end
    end

    always_ff @(posedge clk) begin
        if ((state == RX_DATA) && bit_end) begin
            shreg <= {rxd_sync, shreg[UART_DATA_W-1:1]};
        end
    end

    // --------------------------------------------------
    // Frame FSM
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= RX_IDLE;
            baud_cnt <= '0;
            bit_cnt  <= '0;
        end else begin
            baud_cnt <= baud_cnt + 8'd1;
            case (state)
                RX_IDLE: begin
                    baud_cnt <= '0;
                    if (rxd_prev && !rxd_sync) begin
                        state <= RX_START;
                    end
                end
                // Half a bit in, a high line was only a glitch
                RX_START: begin
                    if (half_end) begin
                        baud_cnt <= '0;
                        bit_cnt  <= '0;
                        state    <= rxd_sync ? RX_IDLE : RX_DATA;
                    end
                end
                RX_DATA: begin
                    if (bit_end) begin
                        baud_cnt <= '0;
                        bit_cnt  <= bit_cnt + 3'd1;
                        if (bit_cnt == 3'd7) begin
                            state <= RX_STOP;
                        end
                    end
                end
                default: begin
                    if (bit_end) begin
                        baud_cnt <= '0;
                        state    <= RX_IDLE;
                    end
                end
            endcase
        end
    end

endmodule

// File: src/uart_top.sv
// UART peripheral top level: register block, transmit and receive FIFOs, transmitter, receiver
module uart_top #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                clk,
    input  logic                rst_n,
    input  uart_pkg::dbus_req_t dbus_req_i,
    output uart_pkg::dbus_rsp_t dbus_rsp_o,
    input  logic                sel_i,
    input  logic                rxd_i,
    output logic                irq_o,
    output logic                txd_o
);

    import uart_pkg::*;

    // Transmit path
    logic                   tx_push;
    logic [UART_DATA_W-1:0] tx_wr_data;
    logic                   tx_full;
    logic                   tx_empty;
    logic                   tx_pop;
    logic [UART_DATA_W-1:0] tx_head;
    logic                   tx_busy;

    // Receive path
    logic                   rx_push;
    rx_entry_t              rx_wr_entry;
    logic                   rx_full;
    logic                   rx_empty;
    logic                   rx_pop;
    rx_entry_t              rx_head;
    logic                   rx_overrun;

    // Line configuration
    logic [7:0]             baud_div;
    logic                   two_stop;

    uart_regs u_regs (
        .clk          (clk),
        .rst_n        (rst_n),
        .dbus_req_i   (dbus_req_i),
        .dbus_rsp_o   (dbus_rsp_o),
        .sel_i        (sel_i),
        .irq_o        (irq_o),
        .tx_push_o    (tx_push),
        .tx_data_o    (tx_wr_data),
        .tx_full_i    (tx_full),
        .tx_empty_i   (tx_empty),
        .rx_pop_o     (rx_pop),
        .rx_entry_i   (rx_head),
        .rx_empty_i   (rx_empty),
        .rx_overrun_i (rx_overrun),
        .tx_busy_i    (tx_busy),
        .baud_div_o   (baud_div),
        .two_stop_o   (two_stop)
    );

    uart_fifo #(
        .payload_t  (logic [UART_DATA_W-1:0]),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_tx_fifo (
        .clk     (clk),
        .rst_n   (rst_n),
        .push_i  (tx_push),
        .data_i  (tx_wr_data),
        .pop_i   (tx_pop),
        .data_o  (tx_head),
        .full_o  (tx_full),
        .empty_o (tx_empty)
    );

    uart_fifo #(
        .payload_t  (rx_entry_t),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_rx_fifo (
        .clk     (clk),
        .rst_n   (rst_n),
        .push_i  (rx_push),
        .data_i  (rx_wr_entry),
        .pop_i   (rx_pop),
        .data_o  (rx_head),
        .full_o  (rx_full),
        .empty_o (rx_empty)
    );

    uart_tx u_tx (
        .clk        (clk),
        .rst_n      (rst_n),
        .baud_div_i (baud_div),
        .two_stop_i (two_stop),
        .empty_i    (tx_empty),
        .data_i     (tx_head),
        .pop_o      (tx_pop),
        .busy_o     (tx_busy),
        .txd_o      (txd_o)
    );

    uart_rx u_rx (
        .clk        (clk),
        .rst_n      (rst_n),
        .baud_div_i (baud_div),
        .rxd_i      (rxd_i),
        .full_i     (rx_full),
        .push_o     (rx_push),
        .entry_o    (rx_wr_entry),
        .overrun_o  (rx_overrun)
    );

endmodule

// File: src/uart_tx.sv
// UART transmitter FSM: pops a byte and sends start, data and stop bits
module uart_tx (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic [7:0]                       baud_div_i,
    input  logic                             two_stop_i,
    input  logic                             empty_i,
    input  logic [uart_pkg::UART_DATA_W-1:0] data_i,
    output logic                             pop_o,
    output logic                             busy_o,
    output logic                             txd_o
);

    import uart_pkg::*;

    typedef enum logic [2:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP1,
        TX_STOP2
    } tx_state_e;

    tx_state_e              state;
    logic [7:0]             baud_cnt;
    logic [2:0]             bit_cnt;
    logic [UART_DATA_W-1:0] shreg;
    logic                   txd_q;
    logic                   bit_end;

    // One bit lasts baud_div + 1 cycles
    assign bit_end = (baud_cnt == baud_div_i);
    assign pop_o   = (state == TX_IDLE) && !empty_i;
    assign busy_o  = (state != TX_IDLE) || pop_o;
    assign txd_o   = txd_q;

    // Character shifts out LSB first
    always_ff @(posedge clk) begin
        if (pop_o) begin
            shreg <= data_i;
        end else if ((state == TX_DATA) && bit_end) begin
            shreg <= shreg >> 1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= TX_IDLE;
            baud_cnt <= '0;
            bit_cnt  <= '0;
            txd_q    <= 1'b1;
        end else if (state == TX_IDLE) begin
            baud_cnt <= '0;
            if (pop_o) begin
                state <= TX_START;
                txd_q <= 1'b0;
            end
        end else if (!bit_end) begin
            baud_cnt <= baud_cnt + 8'd1;
        end else begin
            baud_cnt <= '0;
            case (state)
                TX_START: begin
                    state   <= TX_DATA;
                    bit_cnt <= '0;
                    txd_q   <= shreg[0];
                end
                TX_DATA: begin
                    bit_cnt <= bit_cnt + 3'd1;
                    if (bit_cnt == 3'd7) begin
                        state <= TX_STOP1;
                        txd_q <= 1'b1;
                    end else begin
                        txd_q <= shreg[1];
                    end
                end
                TX_STOP1: state <= two_stop_i ? TX_STOP2 : TX_IDLE;
                default:  state <= TX_IDLE;
            endcase
        end
    end

endmodule

// File: tb/uart_properties.sv
// FIFO assertions on flag exclusion and occupancy bound, bound into every uart_fifo
module fifo_properties #(
    parameter int FIFO_DEPTH = 4
) (
    input logic                                clk,
    input logic                                rst_n,
    input logic                                full_i,
    input logic                                empty_i,
    input logic [$clog2(FIFO_DEPTH):0]         count_i
);

    localparam int CNT_W = $clog2(FIFO_DEPTH) + 1;

    // A FIFO cannot be full and empty at once
    assert property (@(posedge clk) disable iff (!rst_n) !(full_i && empty_i))
        else $error("FIFO reports full and empty in the same cycle");

    // Occupancy stays within the storage
    assert property (@(posedge clk) disable iff (!rst_n) count_i <= CNT_W'(FIFO_DEPTH))
        else $error("FIFO count %0d exceeds depth %0d", count_i, FIFO_DEPTH);

endmodule

bind uart_fifo fifo_properties #(
    .FIFO_DEPTH (FIFO_DEPTH)
) u_fifo_props (
    .clk     (clk),
    .rst_n   (rst_n),
    .full_i  (full_o),
    .empty_i (empty_o),
    .count_i (count)
);

// File: tb/uart_tb.sv
// UART testbench with clock, reset, LCG stimulus, bus tasks, line driver, reference model and watchdog
module uart_tb;

    import uart_pkg::*;

    localparam int FIFO_DEPTH   = 4;
    localparam int DIV_LOOP_MAX = 15;
    localparam int DIV_SLOW     = 40;
    localparam int DIV_LINE     = 10;
    localparam int POLL_LIMIT   = 4000;

    // Twice the summed frame time of all tests at 11 bits per frame
    localparam longint WATCHDOG_TIME = 2 * 100 * 11 *
        (20 * (DIV_LOOP_MAX + 1) + (FIFO_DEPTH + 2) * (DIV_SLOW + 1) +
         (FIFO_DEPTH + 4) * (DIV_LINE + 1));

    localparam logic [7:0] IDLE_STATUS = 8'(1 << ST_TX_IDLE);
    localparam logic [7:0] AVAIL_BIT   = 8'(1 << ST_RX_AVAIL);
    localparam logic [7:0] FERR_BIT    = 8'(1 << ST_FRAME_ERR);
    localparam logic [7:0] OVERRUN_BIT = 8'(1 << ST_RX_OVERRUN);

    logic        clk;
    logic        rst_n;
    dbus_req_t   dbus_req;
    dbus_rsp_t   dbus_rsp;
    logic        sel;
    logic        txd;
    logic        irq;
    logic        line_rxd;
    logic        loopback;
    logic        rxd;
    logic [31:0] seed;
    logic [7:0]  expected_q[$];
    int          errors;
    int          errors_at_start;
    int          tests_run;
    int          tests_failed;

    assign rxd = loopback ? txd : line_rxd;

    uart_top #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .dbus_req_i (dbus_req),
        .dbus_rsp_o (dbus_rsp),
        .sel_i      (sel),
        .rxd_i      (rxd),
        .irq_o      (irq),
        .txd_o      (txd)
    );

    always #50 clk = ~clk;

    // --------------------------------------------------
    // Random numbers and checks
    // --------------------------------------------------
    function automatic logic [31:0] next_random();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic int random_range(input int lo, input int hi);
        logic [31:0] r;
        r = next_random();
        return lo + int'({1'b0, r[31:1]} % 32'(hi - lo + 1));
    endfunction

    function automatic logic [7:0] random_byte();
        logic [31:0] r;
        r = next_random();
        return r[23:16];
    endfunction

    task automatic check_value(input string name, input logic [7:0] expected,
                               input logic [7:0] actual);
        assert (actual === expected) else begin
            $display("[ERROR] t=%0t %s expected %02h got %02h", $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic finish_test(input int num, input string name);
        tests_run++;
        if (errors == errors_at_start) begin
            $display("test %0d %s: pass", num, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: FAIL with %0d errors", num, name, errors - errors_at_start);
        end
        errors_at_start = errors;
    endtask

    // --------------------------------------------------
    // Bus and line tasks
    // --------------------------------------------------
    // Called 10 units after an edge and returns once ack has dropped
    task automatic bus_access(input logic write, input uart_reg_e idx,
                              input logic [7:0] wdata, output logic [7:0] rdata);
        int waited;
        waited          = 0;
        dbus_req.req    = 1'b1;
        dbus_req.w_en   = write;
        dbus_req.addr   = {26'd0, idx, 2'b00};
        dbus_req.w_data = {24'd0, wdata};
        sel             = 1'b1;
        @(posedge clk);
        #10;
        dbus_req.req = 1'b0;
        sel          = 1'b0;
        while (!dbus_rsp.ack && waited < 4) begin
            @(posedge clk);
            #10;
            waited++;
        end
        assert (dbus_rsp.ack) else begin
            $display("t=%0t access to %s was never acknowledged", $time, idx.name());
            errors++;
        end
        rdata = dbus_rsp.r_data[7:0];
        // Byte registers read back zero-extended
        if (!write) begin
            assert (dbus_rsp.r_data[31:8] === 24'd0) else begin
                $display("[ERROR] t=%0t r_data[31:8] expected 000000 got %06h",
                         $time, dbus_rsp.r_data[31:8]);
                errors++;
            end
        end
        @(posedge clk);
        #10;
        // Acknowledge lasts a single cycle
        check_value("ack", 8'h00, {7'd0, dbus_rsp.ack});
    endtask

    task automatic write_reg(input uart_reg_e idx, input logic [7:0] data);
        logic [7:0] unused;
        bus_access(1'b1, idx, data, unused);
    endtask

    task automatic read_reg(input uart_reg_e idx, output logic [7:0] data);
        bus_access(1'b0, idx, 8'h00, data);
    endtask

    task automatic poll_status(input int bit_idx, output logic [7:0] st);
        int polls;
        polls = 0;
        read_reg(STATUS, st);
        while (!st[bit_idx] && polls < POLL_LIMIT) begin
            read_reg(STATUS, st);
            polls++;
        end
        assert (st[bit_idx]) else begin
            $display("t=%0t STATUS bit %0d never set in %0d polls", $time, bit_idx, POLL_LIMIT);
            errors++;
        end
    endtask

    // Pops one received byte and compares it with the model
    task automatic check_rx_byte();
        logic [7:0] data;
        read_reg(TXRX, data);
        assert (expected_q.size() > 0) else begin
            $display("t=%0t byte %02h received while none was expected", $time, data);
            errors++;
        end
        if (expected_q.size() > 0) begin
            check_value("TXRX", expected_q.pop_front(), data);
        end
    endtask

    // Start bit, 8 data bits and one stop bit followed by one idle bit
    task automatic send_frame(input logic [7:0] data, input logic stop_bit, input int div);
        logic [9:0] bits;
        int         i;
        bits = {stop_bit, data, 1'b0};
        for (i = 0; i < 10; i++) begin
            line_rxd = bits[i];
            repeat (div + 1) @(posedge clk);
            #10;
        end
        line_rxd = 1'b1;
        repeat (div + 1) @(posedge clk);
        #10;
    endtask

    task automatic wait_irq(input logic level);
        int waited;
        waited = 0;
        while (irq !== level && waited < 4 * 11 * (DIV_LINE + 1)) begin
            @(posedge clk);
            #10;
            waited++;
        end
        check_value("irq_o", {7'd0, level}, {7'd0, irq});
    endtask

    // --------------------------------------------------
    // Tests
    // --------------------------------------------------
    task automatic test_reset_regs();
        uart_reg_e  regs[4];
        logic [7:0] rd;
        logic [7:0] val;
        int         i;
        regs = '{IE, BAUD, LCTRL, SCRATCH};
        check_value("txd_o", 8'h01, {7'd0, txd});
        check_value("irq_o", 8'h00, {7'd0, irq});
        check_value("ack", 8'h00, {7'd0, dbus_rsp.ack});
        read_reg(IE, rd);
        check_value("IE", 8'h00, rd);
        read_reg(BAUD, rd);
        check_value("BAUD", BAUD_RESET, rd);
        read_reg(LCTRL, rd);
        check_value("LCTRL", 8'h00, rd);
        read_reg(SCRATCH, rd);
        check_value("SCRATCH", 8'h00, rd);
        read_reg(STATUS, rd);
        check_value("STATUS", IDLE_STATUS, rd);
        for (i = 0; i < 4; i++) begin
            val = random_byte();
            write_reg(regs[i], val);
            read_reg(regs[i], rd);
            check_value(regs[i].name(), val, rd);
        end
        // STATUS is read only
        write_reg(STATUS, random_byte());
        read_reg(STATUS, rd);
        check_value("STATUS", IDLE_STATUS, rd);
        write_reg(IE, 8'h00);
        write_reg(BAUD, BAUD_RESET);
        write_reg(LCTRL, 8'h00);
        finish_test(1, "reset and registers");
    endtask

    task automatic test_loopback();
        logic [7:0] st;
        logic [7:0] data;
        int         div;
        int         sent;
        int         got;
        div  = random_range(3, DIV_LOOP_MAX);
        sent = 0;
        got  = 0;
        write_reg(BAUD, 8'(div));
        write_reg(LCTRL, random_byte() & 8'h01);
        loopback = 1'b1;
        // Draining the receive side has priority over sending
        while (got < 20) begin
            read_reg(STATUS, st);
            check_value("STATUS.frame_err", 8'h00, {7'd0, st[ST_FRAME_ERR]});
            check_value("STATUS.rx_overrun", 8'h00, {7'd0, st[ST_RX_OVERRUN]});
            if (st[ST_RX_AVAIL]) begin
                check_rx_byte();
                got++;
            end else if (sent < 20 && !st[ST_TX_FULL]) begin
                data = random_byte();
                write_reg(TXRX, data);
                expected_q.push_back(data);
                sent++;
            end
        end
        poll_status(ST_TX_IDLE, st);
        check_value("STATUS", IDLE_STATUS, st);
        finish_test(2, "loopback data");
    endtask

    task automatic test_tx_overflow();
        logic [7:0] st;
        logic [7:0] data;
        int         i;
        write_reg(BAUD, 8'(DIV_SLOW));
        write_reg(LCTRL, 8'h00);
        // One byte goes to the transmitter and the last write is dropped
        for (i = 0; i < FIFO_DEPTH + 2; i++) begin
            data = random_byte();
            write_reg(TXRX, data);
            if (i < FIFO_DEPTH + 1) begin
                expected_q.push_back(data);
            end
        end
        read_reg(STATUS, st);
        check_value("STATUS.tx_full", 8'h01, {7'd0, st[ST_TX_FULL]});
        while (expected_q.size() > 0) begin
            poll_status(ST_RX_AVAIL, st);
            check_rx_byte();
        end
        poll_status(ST_TX_IDLE, st);
        read_reg(STATUS, st);
        check_value("STATUS", IDLE_STATUS, st);
        loopback = 1'b0;
        finish_test(3, "transmit overflow");
    endtask

    task automatic test_framing_error();
        logic [7:0] st;
        logic [7:0] data;
        write_reg(BAUD, 8'(DIV_LINE));
        data = random_byte();
        expected_q.push_back(data);
        send_frame(data, 1'b0, DIV_LINE);
        poll_status(ST_RX_AVAIL, st);
        check_rx_byte();
        read_reg(STATUS, st);
        check_value("STATUS", IDLE_STATUS | FERR_BIT, st);
        read_reg(STATUS, st);
        check_value("STATUS", IDLE_STATUS, st);
        finish_test(4, "framing error");
    endtask

    task automatic test_rx_overrun();
        logic [7:0] st;
        logic [7:0] data;
        int         i;
        for (i = 0; i < FIFO_DEPTH + 1; i++) begin
            data = random_byte();
            if (i < FIFO_DEPTH) begin
                expected_q.push_back(data);
            end
            send_frame(data, 1'b1, DIV_LINE);
        end
        read_reg(STATUS, st);
        check_value("STATUS", IDLE_STATUS | AVAIL_BIT | OVERRUN_BIT, st);
        for (i = 0; i < FIFO_DEPTH; i++) begin
            check_rx_byte();
        end
        read_reg(STATUS, st);
        check_value("STATUS", IDLE_STATUS, st);
        finish_test(5, "receive overrun");
    endtask

    task automatic test_interrupt();
        logic [7:0] st;
        logic [7:0] data;
        int         high_cycles;
        write_reg(IE, AVAIL_BIT);
        check_value("irq_o", 8'h00, {7'd0, irq});
        data = random_byte();
        expected_q.push_back(data);
        send_frame(data, 1'b1, DIV_LINE);
        wait_irq(1'b1);
        check_rx_byte();
        wait_irq(1'b0);
        // A masked received byte must not raise the line
        write_reg(IE, 8'h00);
        data = random_byte();
        expected_q.push_back(data);
        send_frame(data, 1'b1, DIV_LINE);
        high_cycles = 0;
        repeat (2 * (DIV_LINE + 1)) begin
            if (irq) begin
                high_cycles++;
            end
            @(posedge clk);
            #10;
        end
        check_value("irq_o high cycles", 8'h00, 8'(high_cycles));
        read_reg(STATUS, st);
        check_value("STATUS", IDLE_STATUS | AVAIL_BIT, st);
        check_rx_byte();
        finish_test(6, "interrupt");
    endtask

    // --------------------------------------------------
    // Sequence and watchdog
    // --------------------------------------------------
    initial begin
        clk             = 1'b0;
        rst_n           = 1'b0;
        dbus_req        = '0;
        sel             = 1'b0;
        line_rxd        = 1'b1;
        loopback        = 1'b0;
        seed            = 32'hc59e_c982;
        errors          = 0;
        errors_at_start = 0;
        tests_run       = 0;
        tests_failed    = 0;
        repeat (5) @(posedge clk);
        #10;
        rst_n = 1'b1;
        test_reset_regs();
        test_loopback();
        test_tx_overflow();
        test_framing_error();
        test_rx_overrun();
        test_interrupt();
        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_TIME);
        $display("t=%0t watchdog expired before the tests finished", $time);
        $display("Something failed");
        $finish;
    end

endmodule
